/* filelist.f */
+incdir+hw
hw/ntt_ctrl_pkg.sv
hw/load_sequencer.sv
hw/phase_timer.sv
hw/ntt_sequencer.sv
hw/ntt_controller.sv
bench/ntt_checker.sv
bench/tb_ntt_controller.sv

/* run_sim.sh */
#!/bin/sh
# Builds the NTT controller testbench with Verilator, runs it and checks the log.
rm -rf obj_dir sim.log
verilator --binary --timing -f filelist.f --top-module tb_ntt_controller -o sim_ntt \
    && ./obj_dir/sim_ntt > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

/* bench/tb_ntt_controller.sv */
// Top testbench of the NTT controller.
// Runs back-to-back operations with seeded random beats, gaps, stray starts and
// mode changes; ntt_checker compares every cycle.
`timescale 1ns/1ps
`include "ntt_cfg.svh"

module tb_ntt_controller import ntt_ctrl_pkg::*; ();

    localparam int OPS   = 4;
    localparam int BEATS = 128;
    localparam int LIMIT = OPS * (4 * BEATS + `NTT_DECO_LATE + `NTT_EXEC_CYCLE + 20);

    logic        clk_i;
    logic        rst_i;
    logic        start;
    logic        is_ntt;
    logic        valid_input;
    coeff_word_t din;
    load_wr_t    load_wr;
    phase_ctrl_t phase;
    logic        done_all;
    int          error_count;
    int          check_count;
    int          op_count;
    int          seed = 32'he6b0e5ea;
    int          cycles = 0;

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;               // 40 ns period
    end

    ntt_controller dut0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start       (start),
        .is_ntt      (is_ntt),
        .valid_input (valid_input),
        .din         (din),
        .load_wr     (load_wr),
        .phase       (phase),
        .done_all    (done_all)
    );

    ntt_checker chk0 (
        .clk_i, .rst_i, .start, .is_ntt, .valid_input, .din,
        .load_wr, .phase, .done_all,
        .error_count, .check_count, .op_count
    );

    function automatic coeff_word_t random_word();
        return {$random(seed), $random(seed), $random(seed),
                $random(seed), $random(seed), $random(seed)};
    endfunction

    // One operation, from stray idle beats to the done pulse
    task automatic run_operation();
        logic seen_done;
        seen_done = 1'b0;
        repeat (3) begin                          // Beats before start are dropped
            @(negedge clk_i);
            start       = 1'b0;
            valid_input = 1'b1;
            din         = random_word();
        end
        @(negedge clk_i);
        start       = 1'b1;
        is_ntt      = 1'($random(seed));
        valid_input = 1'b0;
        while (!seen_done) begin
            @(negedge clk_i);
            seen_done   = done_all;
            start       = ($random(seed) & 31) == 0;   // Busy starts, ignored
            is_ntt      = 1'($random(seed));            // Late mode changes, ignored
            valid_input = ($random(seed) & 3) != 0;     // Roughly one gap in four
            din         = random_word();
        end
        @(negedge clk_i);
        start       = 1'b0;
        valid_input = 1'b0;
    endtask

    initial begin
        rst_i       = 1'b1;
        start       = 1'b0;
        is_ntt      = 1'b0;
        valid_input = 1'b0;
        din         = '0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        repeat (OPS) run_operation();
        repeat (2) @(negedge clk_i);              // Let the last test line print
        if (op_count != OPS) begin
            $display("Only %0d of %0d operations completed", op_count, OPS);
        end
        $display("Checks: %0d, errors: %0d, operations: %0d",
                 check_count, error_count, op_count);
        if (error_count == 0 && op_count == OPS) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Run limit from the worst-case operation length
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: %0d operations did not finish within %0d cycles", OPS, LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

endmodule

/* bench/ntt_checker.sv */
// Reference model and comparator for the NTT controller testbench.
// Tracks beats and phase cycles from the DUT inputs and compares outputs at the falling edge.
`timescale 1ns/1ps
`include "ntt_cfg.svh"

module ntt_checker import ntt_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        start,
    input  logic        is_ntt,
    input  logic        valid_input,
    input  coeff_word_t din,
    input  load_wr_t    load_wr,
    input  phase_ctrl_t phase,
    input  logic        done_all,
    output int          error_count,
    output int          check_count,
    output int          op_count
);

    localparam int PAIRS = `NTT_COEFFS_PER_WORD / 2;
    localparam int BEATS = PAIRS * `NTT_ROWS_PER_BANK * `NTT_BANKS;  // 128 beats per load

    typedef enum int {M_IDLE, M_LOAD, M_GAP, M_DECODE, M_EXEC, M_DONE} model_state_t;

    model_state_t m_state;
    logic         m_active;      // Reset seen released at a rising edge
    int           beat;          // Index of the next accepted beat
    int           ph_cnt;        // Cycle inside decode or execute
    logic         m_mode;        // is_ntt captured at start
    load_wr_t     exp_wr;
    phase_ctrl_t  exp_ph;
    int           op_writes;     // Writes seen on the DUT in this operation
    int           op_err_base;

    // Coefficient k of a word with coefficient 0 at the top
    function automatic coeff_t coeff_at(input coeff_word_t word, input int k);
        return coeff_t'(word >> (`NTT_WORD_W - (k + 1) * `NTT_COEFF_W));
    endfunction

    // Pair p, row group r and bank b from the beat index
    function automatic load_wr_t expected_write(input int n, input coeff_word_t word);
        load_wr_t w;
        int       p;
        int       r;
        int       b;
        p = n % PAIRS;
        r = (n / PAIRS) % `NTT_ROWS_PER_BANK;
        b = n / (PAIRS * `NTT_ROWS_PER_BANK);
        w.we     = bank_we_t'(1) << b;
        w.addr_a = bank_addr_t'(r * 16 + p * 2);
        w.addr_b = bank_addr_t'(r * 16 + p * 2 + 1);
        w.data_a = coeff_at(word, 2 * p);
        w.data_b = coeff_at(word, 2 * p + 1);
        return w;
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    // Model advances on the same edge as the DUT
    always @(posedge clk_i) begin
        if (rst_i) begin
            m_state  <= M_IDLE;
            m_active <= 1'b0;
            beat     <= 0;
            ph_cnt   <= 0;
            m_mode   <= 1'b0;
            exp_wr   <= '0;
        end else begin
            m_active  <= 1'b1;
            exp_wr.we <= '0;                        // No write unless a beat lands
            case (m_state)
                M_IDLE: if (start) begin
                    m_mode  <= is_ntt;
                    m_state <= M_LOAD;
                end
                M_LOAD: if (valid_input) begin
                    exp_wr <= expected_write(beat, din);
                    beat   <= (beat == BEATS - 1) ? 0 : beat + 1;
                    if (beat == BEATS - 1) m_state <= M_GAP;
                end
                M_GAP: begin                        // Launch cycle without flags
                    m_state <= M_DECODE;
                    ph_cnt  <= 0;
                end
                M_DECODE: begin
                    ph_cnt <= (ph_cnt == `NTT_DECO_LATE - 1) ? 0 : ph_cnt + 1;
                    if (ph_cnt == `NTT_DECO_LATE - 1) m_state <= M_EXEC;
                end
                M_EXEC: begin
                    ph_cnt <= ph_cnt + 1;
                    if (ph_cnt == `NTT_EXEC_CYCLE - 1) m_state <= M_DONE;
                end
                default: m_state <= M_IDLE;         // DONE lasts one cycle
            endcase
        end
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clk_i) begin
        if (!m_active) begin
            error_count = 0;
            check_count = 0;
            op_count    = 0;
            op_writes   = 0;
            op_err_base = 0;
        end else begin
            exp_ph.start_decode     = (m_state == M_DECODE);
            exp_ph.start_bu_choose  = (m_state == M_DECODE) || (m_state == M_EXEC);
            exp_ph.start_bram_exec  = (m_state == M_EXEC);
            exp_ph.start_bram_write = (m_state == M_EXEC) && (ph_cnt >= `NTT_BU_LATE);
            exp_ph.is_ntt_decode    = (m_state == M_DECODE) && m_mode;
            exp_ph.is_ntt_exec      = (m_state == M_EXEC) && m_mode;
            check_field("load_wr.we", 64'(load_wr.we), 64'(exp_wr.we));
            if (exp_wr.we != '0) begin              // Payload only matters with a write
                check_field("load_wr.addr_a", 64'(load_wr.addr_a), 64'(exp_wr.addr_a));
                check_field("load_wr.addr_b", 64'(load_wr.addr_b), 64'(exp_wr.addr_b));
                check_field("load_wr.data_a", 64'(load_wr.data_a), 64'(exp_wr.data_a));
                check_field("load_wr.data_b", 64'(load_wr.data_b), 64'(exp_wr.data_b));
            end
            check_field("phase", 64'(phase), 64'(exp_ph));
            check_field("done_all", 64'(done_all), 64'(m_state == M_DONE));
            if (load_wr.we != '0) op_writes++;
            if (m_state == M_DONE) begin
                op_count++;
                if (op_writes != BEATS) begin
                    error_count++;
                    $display("Operation %0d wrote %0d coefficient pairs instead of %0d",
                             op_count, op_writes, BEATS);
                end
                $display("Test %0d (load and phases, mode %0d) finished with %0d errors",
                         op_count, m_mode, error_count - op_err_base);
                op_err_base = error_count;
                op_writes   = 0;
            end
        end
    end

endmodule

/* hw/ntt_controller.sv */
// Top level of the NTT sequencing controller.
// Wires the FSM, the load path and the phase timer together.
`timescale 1ns/1ps

module ntt_controller import ntt_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        start,
    input  logic        is_ntt,
    input  logic        valid_input,
    input  coeff_word_t din,
    output load_wr_t    load_wr,
    output phase_ctrl_t phase,
    output logic        done_all
);

    logic load_en;
    logic load_last;
    logic phase_go;
    logic phase_end;
    logic mode;

    // Control FSM
    ntt_sequencer u_seq (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start       (start),
        .is_ntt      (is_ntt),
        .valid_input (valid_input),
        .load_last   (load_last),
        .phase_end   (phase_end),
        .load_en     (load_en),
        .phase_go    (phase_go),
        .mode        (mode),
        .done_all    (done_all)
    );

    // Bank writes
    load_sequencer u_load (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .load_en   (load_en),
        .din       (din),
        .load_wr   (load_wr),
        .load_last (load_last)
    );

    // Decode / execute flags
    phase_timer u_timer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .phase_go  (phase_go),
        .mode      (mode),
        .phase     (phase),
        .phase_end (phase_end)
    );

endmodule

/* hw/ntt_sequencer.sv */
// Top FSM of the NTT controller.
// Accepts start in IDLE, gates input beats during LOAD, launches the phase
// timer after the last beat and raises done_all for one cycle at the end.
`timescale 1ns/1ps

module ntt_sequencer import ntt_ctrl_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic start,
    input  logic is_ntt,
    input  logic valid_input,
    input  logic load_last,    // From load_sequencer
    input  logic phase_end,    // From phase_timer
    output logic load_en,
    output logic phase_go,
    output logic mode,
    output logic done_all
);

    seq_state_t state;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state    <= IDLE;
            phase_go <= 1'b0;
        end else begin
            phase_go <= 1'b0;                  // Pulse by default
            case (state)
                IDLE: begin
                    if (start) state <= LOAD;
                end
                LOAD: begin
                    if (load_last) begin
                        state    <= PHASE;
                        phase_go <= 1'b1;     // Timer starts its flags next cycle
                    end
                end
                PHASE: begin
                    if (phase_end) state <= DONE;
                end
                DONE: state <= IDLE;           // Single done cycle
                default: state <= IDLE;
            endcase
        end
    end

    // Mode is frozen at start, later is_ntt changes are ignored
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mode <= 1'b0;
        end else if (state == IDLE && start) begin
            mode <= is_ntt;
        end
    end

    assign load_en  = valid_input && (state == LOAD);  // No back-pressure, beats outside LOAD drop
    assign done_all = (state == DONE);

endmodule

/* hw/phase_timer.sv */
// Decode and execute phase timing of the NTT controller.
// A phase_go pulse starts decode on the next cycle, execute follows,
// and phase_end marks the last execute cycle.
`timescale 1ns/1ps
`include "ntt_cfg.svh"

module phase_timer import ntt_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        phase_go,   // One-cycle launch from the sequencer
    input  logic        mode,       // 1 = forward NTT, held by the sequencer
    output phase_ctrl_t phase,
    output logic        phase_end   // High during the last execute cycle
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_DECODE,
        PH_EXEC
    } sub_phase_t;

    // Counter must reach the longest phase
    localparam int CNT_W = $clog2(`NTT_EXEC_CYCLE);

    sub_phase_t       sub_q;
    logic [CNT_W-1:0] cnt_q;       // Cycles spent in the current sub-phase
    logic             decode_last;
    logic             exec_last;

    assign decode_last = (sub_q == PH_DECODE) && (cnt_q == CNT_W'(`NTT_DECO_LATE - 1));
    assign exec_last   = (sub_q == PH_EXEC) && (cnt_q == CNT_W'(`NTT_EXEC_CYCLE - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sub_q <= PH_IDLE;
            cnt_q <= '0;
        end else begin
            case (sub_q)
                PH_IDLE: begin
                    if (phase_go) begin   // Launch ignored while a phase runs
                        sub_q <= PH_DECODE;
                        cnt_q <= '0;
                    end
                end
                PH_DECODE: begin
                    if (decode_last) begin
                        sub_q <= PH_EXEC;
                        cnt_q <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                PH_EXEC: begin
                    if (exec_last) begin
                        sub_q <= PH_IDLE;
                        cnt_q <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: sub_q <= PH_IDLE;
            endcase
        end
    end

    // Flags decode straight from the registered sub-phase and count
    always_comb begin
        phase.start_decode     = (sub_q == PH_DECODE);
        phase.start_bu_choose  = (sub_q != PH_IDLE);             // Spans both phases
        phase.start_bram_exec  = (sub_q == PH_EXEC);
        phase.start_bram_write = (sub_q == PH_EXEC)
                                 && (cnt_q >= CNT_W'(`NTT_BU_LATE));  // First results out
        phase.is_ntt_decode    = (sub_q == PH_DECODE) && mode;
        phase.is_ntt_exec      = (sub_q == PH_EXEC) && mode;
    end

    assign phase_end = exec_last;

endmodule

/* hw/load_sequencer.sv */
// Load path of the NTT controller.
// Turns each enabled input beat into one registered coefficient-pair write,
// walking pair index, row group and bank in that order.
`timescale 1ns/1ps
`include "ntt_cfg.svh"

module load_sequencer import ntt_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        load_en,    // Accepted beat, already gated by LOAD
    input  coeff_word_t din,
    output load_wr_t    load_wr,
    output logic        load_last   // High on the accepting cycle of beat 127
);

    localparam int PAIRS  = `NTT_COEFFS_PER_WORD / 2;
    localparam int PAIR_W = $clog2(PAIRS);
    localparam int ROW_W  = $clog2(`NTT_ROWS_PER_BANK);
    localparam int BANK_W = $clog2(`NTT_BANKS);

    logic [PAIR_W-1:0] pair_cnt;   // p = n mod 8
    logic [ROW_W-1:0]  row_cnt;    // r = (n div 8) mod 2
    logic [BANK_W-1:0] bank_cnt;   // b = n div 16
    logic              pair_wrap;
    logic              row_wrap;

    coeff_t            coeffs [`NTT_COEFFS_PER_WORD];

    bank_we_t                  we_q;
    logic [PAIR_W+ROW_W-1:0]   row_base_q;   // {r, p}, the port bit is appended below
    coeff_t                    data_a_q;
    coeff_t                    data_b_q;

    // Unpack the word, coefficient 0 is the top slice
    always_comb begin
        for (int k = 0; k < `NTT_COEFFS_PER_WORD; k++) begin
            coeffs[k] = din[`NTT_WORD_W-1-k*`NTT_COEFF_W -: `NTT_COEFF_W];
        end
    end

    assign pair_wrap = (pair_cnt == PAIR_W'(PAIRS - 1));
    assign row_wrap  = (row_cnt == ROW_W'(`NTT_ROWS_PER_BANK - 1));
    assign load_last = load_en && pair_wrap && row_wrap
                       && (bank_cnt == BANK_W'(`NTT_BANKS - 1));

    // Beat counters, all three roll over to zero on the last beat
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pair_cnt <= '0;
            row_cnt  <= '0;
            bank_cnt <= '0;
        end else if (load_en) begin
            pair_cnt <= pair_cnt + 1'b1;            // Natural wrap at 8
            if (pair_wrap) begin
                row_cnt <= row_cnt + 1'b1;
                if (row_wrap) begin
                    bank_cnt <= bank_cnt + 1'b1;   // Wraps after bank 7
                end
            end
        end
    end

    // Write-enable lives exactly one cycle per accepted beat
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            we_q <= '0;
        end else if (load_en) begin
            we_q <= bank_we_t'(1) << bank_cnt;
        end else begin
            we_q <= '0;
        end
    end

    // Payload only changes with a beat
    always_ff @(posedge clk_i) begin
        if (load_en) begin
            row_base_q <= {row_cnt, pair_cnt};
            data_a_q   <= coeffs[{pair_cnt, 1'b0}];  // Even coefficient 2p
            data_b_q   <= coeffs[{pair_cnt, 1'b1}];  // Odd coefficient 2p+1
        end
    end

    // addr_a = r*16 + 2p, addr_b one row above
    assign load_wr = '{
        we:     we_q,
        addr_a: {row_base_q, 1'b0},
        addr_b: {row_base_q, 1'b1},
        data_a: data_a_q,
        data_b: data_b_q
    };

endmodule

/* hw/ntt_ctrl_pkg.sv */
// Shared types of the NTT sequencing controller.
// Imported by every RTL block that passes coefficients, bank writes or phase flags.
package ntt_ctrl_pkg;

`include "ntt_cfg.svh"

    // Plain vectors with a meaning
    typedef logic [`NTT_COEFF_W-1:0] coeff_t;       // One coefficient
    typedef logic [`NTT_WORD_W-1:0]  coeff_word_t;  // Coefficient 0 in the top bits
    typedef logic [`NTT_ADDR_W-1:0]  bank_addr_t;   // Row address of one bank port
    typedef logic [`NTT_BANKS-1:0]   bank_we_t;     // One write-enable per bank

    // One coefficient-pair write into a two-port bank
    typedef struct packed {
        bank_we_t   we;      // One-hot, zero when no write
        bank_addr_t addr_a;  // Even coefficient row
        bank_addr_t addr_b;  // Odd coefficient row, addr_a + 1
        coeff_t     data_a;  // Coefficient 2p
        coeff_t     data_b;  // Coefficient 2p+1
    } load_wr_t;

    // Phase flags towards the datapath
    typedef struct packed {
        logic start_decode;
        logic start_bu_choose;   // Covers decode and execute
        logic start_bram_exec;
        logic start_bram_write;  // Write-back, delayed by the butterfly latency
        logic is_ntt_decode;
        logic is_ntt_exec;
    } phase_ctrl_t;

    // Top sequencer FSM
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        PHASE,
        DONE
    } seq_state_t;

endpackage

/* hw/ntt_cfg.svh */
// Widths, bank organisation and phase latencies of the NTT sequencing controller.
// Included by the package, by the RTL that uses these numbers and by the testbench.
`ifndef NTT_CFG_SVH
`define NTT_CFG_SVH

// Coefficient and input word shape
`define NTT_COEFF_W          12
`define NTT_COEFFS_PER_WORD  16
`define NTT_WORD_W           192   // 16 coefficients of 12 bits

// Bank organisation
`define NTT_BANKS            8
`define NTT_ROWS_PER_BANK    2     // Row groups per bank, the "time" counter
`define NTT_ADDR_W           5     // Row group, pair index and port bit

// Phase timing in clock cycles
`define NTT_DECO_LATE        2     // Decode phase length
`define NTT_EXEC_CYCLE       120   // Execute phase length
`define NTT_BU_LATE          7     // Butterfly pipeline depth before write-back

`endif
